// ==== core_pkg.sv ====
package core_pkg;

    // ========================================================================
    // widths and register numbers
    // ========================================================================
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regid_t;

    localparam regid_t R0 = 5'd0;   // hardwired zero.
    localparam regid_t RA = 5'd31;  // link target.

    typedef enum logic [2:0] {
        FU_NONE, ALU, BRU, AGU, HILO, CP0, MLT
    } fu_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_LINK, OP_LW, OP_SW,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MFC0_EPC, OP_MFC0_BADVADDR, OP_ERET, OP_MULT
    } op_t;

    typedef enum logic [4:0] {
        EX_INT  = 5'd0,
        EX_ADEL = 5'd4,
        EX_ADES = 5'd5,
        EX_SYS  = 5'd8,
        EX_BP   = 5'd9,
        EX_RI   = 5'd10,
        EX_OV   = 5'd12,
        EX_NONE = 5'd31   // no exception.
    } ecode_t;

    // ========================================================================
    // pipeline payloads
    // ========================================================================
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        fu_t    fu;
        op_t    op;
        regid_t rs;
        regid_t rt;
        regid_t target_reg;
        word_t  imm;        // already sign extended.
        logic   syscall;
        logic   brk;
        logic   ri;
    } micro_op_t;

    typedef struct packed {
        micro_op_t [1:0] lane;  // lane 0 is older.
    } issue_bundle_t;

    typedef struct packed {
        logic        valid;
        addr_t       pc;
        fu_t         fu;
        regid_t      target_reg;
        word_t       result;
        logic [63:0] product;
        logic        write_hi;
        logic        write_lo;
        logic        ov;
        logic        adel;
        logic        ades;
        logic        sys;
        logic        bp;
        logic        ri;
        logic        eret;
        addr_t       badvaddr;
    } lane_result_t;

    typedef struct packed {
        lane_result_t [1:0] lane;
    } exec_result_t;

    typedef struct packed {
        logic   exception_en;
        logic   eret;
        logic   bd;
        addr_t  epc;
        addr_t  badvaddr;
        ecode_t exe_code;
    } cp0_update_t;

    typedef struct packed {
        logic       exl;
        logic [7:0] im;
        logic [7:0] ip;
        addr_t      epc;
        addr_t      badvaddr;
    } cp0_view_t;

    typedef struct packed {
        addr_t  pc;
        logic   wen;
        regid_t wnum;
        word_t  wdata;
    } trace_t;

    typedef struct packed {
        logic   valid;
        ecode_t exe_code;
        logic   bd;
        addr_t  epc;
        addr_t  badvaddr;
    } exc_report_t;

endpackage

// ==== issue_exec.sv ====
module issue_exec (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  core_pkg::issue_bundle_t issue,
    output core_pkg::regid_t [3:0] rf_raddr,
    input  core_pkg::word_t [3:0]  rf_rdata,
    input  core_pkg::word_t        hi,
    input  core_pkg::word_t        lo,
    input  core_pkg::cp0_view_t    cp0,
    output core_pkg::exec_result_t exec_result
);

    core_pkg::exec_result_t exec_next;

    // rs then rt for each lane.
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_raddr[2*i]   = issue.lane[i].rs;
            rf_raddr[2*i+1] = issue.lane[i].rt;
        end
    end

    // ========================================================================
    // functional units, one set per lane
    // ========================================================================
    always_comb begin
        core_pkg::micro_op_t uop;
        core_pkg::word_t     rs_val;
        core_pkg::word_t     rt_val;
        core_pkg::addr_t     addr;
        logic [32:0]         sum;
        logic                misaligned;
        exec_next = '0;
        for (int i = 0; i < 2; i++) begin
            uop        = issue.lane[i];
            rs_val     = rf_rdata[2*i];
            rt_val     = rf_rdata[2*i+1];
            addr       = rs_val + uop.imm;
            misaligned = addr[1:0] != 2'b00;
            if (uop.op == core_pkg::OP_SUB)
                sum = {rs_val[31], rs_val} - {rt_val[31], rt_val};
            else
                sum = {rs_val[31], rs_val} + {rt_val[31], rt_val};

            exec_next.lane[i].valid      = issue_valid && uop.valid;
            exec_next.lane[i].pc         = uop.pc;
            exec_next.lane[i].fu         = uop.fu;
            exec_next.lane[i].target_reg = uop.target_reg;
            exec_next.lane[i].product    = $signed(rs_val) * $signed(rt_val);
            exec_next.lane[i].sys        = uop.syscall;
            exec_next.lane[i].bp         = uop.brk;
            exec_next.lane[i].ri         = uop.ri;

            unique case (uop.fu)
                core_pkg::ALU: begin
                    exec_next.lane[i].result = sum[31:0];
                    exec_next.lane[i].ov     = sum[32] != sum[31];  // sign bits disagree.
                end
                core_pkg::BRU: begin
                    exec_next.lane[i].result     = uop.pc + 32'd8;
                    exec_next.lane[i].target_reg = core_pkg::RA;
                end
                core_pkg::AGU: begin
                    exec_next.lane[i].result   = addr;
                    exec_next.lane[i].badvaddr = addr;
                    exec_next.lane[i].adel     = uop.op == core_pkg::OP_LW && misaligned;
                    exec_next.lane[i].ades     = uop.op == core_pkg::OP_SW && misaligned;
                end
                core_pkg::HILO: begin
                    if (uop.op == core_pkg::OP_MFHI)
                        exec_next.lane[i].result = hi;
                    else if (uop.op == core_pkg::OP_MFLO)
                        exec_next.lane[i].result = lo;
                    else
                        exec_next.lane[i].result = rs_val;  // mthi/mtlo source.
                    exec_next.lane[i].write_hi = uop.op == core_pkg::OP_MTHI;
                    exec_next.lane[i].write_lo = uop.op == core_pkg::OP_MTLO;
                end
                core_pkg::CP0: begin
                    if (uop.op == core_pkg::OP_MFC0_BADVADDR)
                        exec_next.lane[i].result = cp0.badvaddr;
                    else
                        exec_next.lane[i].result = cp0.epc;
                    exec_next.lane[i].eret = uop.op == core_pkg::OP_ERET;
                end
                core_pkg::MLT: begin
                    exec_next.lane[i].result = exec_next.lane[i].product[31:0];
                end
                default: begin
                    exec_next.lane[i].target_reg = core_pkg::R0;  // bubble writes nothing.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        exec_result <= exec_next;
        if (rst) begin
            exec_result.lane[0].valid <= 1'b0;
            exec_result.lane[1].valid <= 1'b0;
        end
    end

endmodule

// ==== commit.sv ====
module commit (
    input  core_pkg::exec_result_t exec_result,
    input  core_pkg::cp0_view_t    cp0,
    output core_pkg::regid_t       wa0,
    output core_pkg::regid_t       wa1,
    output core_pkg::word_t        wd0,
    output core_pkg::word_t        wd1,
    output logic                   we0,
    output logic                   we1,
    output logic                   write_hi,
    output logic                   write_lo,
    output core_pkg::word_t        hi_data,
    output core_pkg::word_t        lo_data,
    output core_pkg::cp0_update_t  cp0_upd,
    output core_pkg::trace_t       trace0,
    output core_pkg::trace_t       trace1,
    output logic [1:0]             trace_push
);

    // in-lane priority of synchronous causes.
    function automatic core_pkg::ecode_t lane_cause(input core_pkg::lane_result_t r);
        if (r.ri)
            return core_pkg::EX_RI;
        else if (r.ov)
            return core_pkg::EX_OV;
        else if (r.sys)
            return core_pkg::EX_SYS;
        else if (r.bp)
            return core_pkg::EX_BP;
        else if (r.adel)
            return core_pkg::EX_ADEL;
        else if (r.ades)
            return core_pkg::EX_ADES;
        return core_pkg::EX_NONE;
    endfunction

    core_pkg::lane_result_t l0;
    core_pkg::lane_result_t l1;
    core_pkg::ecode_t       cause0;
    core_pkg::ecode_t       cause1;
    core_pkg::word_t [1:0]  wd;
    logic [1:0]             we;
    logic [1:0]             keep;
    logic                   int_taken;
    logic                   exc0;
    logic                   exc1;

    assign l0        = exec_result.lane[0];
    assign l1        = exec_result.lane[1];
    assign cause0    = lane_cause(l0);
    assign cause1    = lane_cause(l1);
    assign int_taken = l0.valid && !cp0.exl && |(cp0.ip & cp0.im);

    // ========================================================================
    // exception ranking
    // ========================================================================
    always_comb begin
        exc0             = 1'b0;
        exc1             = 1'b0;
        cp0_upd          = '0;
        cp0_upd.exe_code = core_pkg::EX_NONE;
        if (int_taken) begin
            exc0             = 1'b1;
            cp0_upd.epc      = l0.pc + 32'd4;
            cp0_upd.exe_code = core_pkg::EX_INT;
        end else if (l0.valid && cause0 != core_pkg::EX_NONE) begin
            exc0             = 1'b1;
            cp0_upd.epc      = l0.pc;
            cp0_upd.exe_code = cause0;
            cp0_upd.badvaddr = l0.badvaddr;
        end else if (l1.valid && cause1 != core_pkg::EX_NONE) begin
            exc1             = 1'b1;
            cp0_upd.epc      = l1.pc;
            cp0_upd.exe_code = cause1;
            cp0_upd.badvaddr = l1.badvaddr;
            if (l0.valid && l0.fu == core_pkg::BRU) begin
                cp0_upd.bd  = 1'b1;  // lane 1 sits in the delay slot.
                cp0_upd.epc = l1.pc - 32'd4;
            end
        end
        cp0_upd.exception_en = exc0 || exc1;
        keep[0] = l0.valid && !exc0;
        keep[1] = l1.valid && !exc0 && !exc1;
        cp0_upd.eret = !cp0_upd.exception_en
                     && ((keep[0] && l0.eret) || (keep[1] && l1.eret));
    end

    // register and hi/lo writes; lane 1 overrides lane 0.
    always_comb begin
        core_pkg::lane_result_t r;
        write_hi = 1'b0;
        write_lo = 1'b0;
        hi_data  = '0;
        lo_data  = '0;
        for (int i = 0; i < 2; i++) begin
            r     = exec_result.lane[i];
            we[i] = keep[i] && r.target_reg != core_pkg::R0;
            wd[i] = we[i] ? r.result : '0;
            if (keep[i] && r.fu == core_pkg::MLT) begin
                write_hi = 1'b1;
                write_lo = 1'b1;
                hi_data  = r.product[63:32];
                lo_data  = r.product[31:0];
            end
            if (keep[i] && r.write_hi) begin
                write_hi = 1'b1;
                hi_data  = r.result;
            end
            if (keep[i] && r.write_lo) begin
                write_lo = 1'b1;
                lo_data  = r.result;
            end
        end
    end

    assign wa0 = l0.target_reg;
    assign wa1 = l1.target_reg;
    assign wd0 = wd[0];
    assign wd1 = wd[1];
    assign we0 = we[0];
    assign we1 = we[1];

    assign trace0     = '{pc: l0.pc, wen: we[0], wnum: l0.target_reg, wdata: wd[0]};
    assign trace1     = '{pc: l1.pc, wen: we[1], wnum: l1.target_reg, wdata: wd[1]};
    assign trace_push = keep;

endmodule

// ==== arch_state.sv ====
module arch_state (
    input  logic                   clk,
    input  logic                   rst,
    input  core_pkg::regid_t       wa0,
    input  core_pkg::regid_t       wa1,
    input  core_pkg::word_t        wd0,
    input  core_pkg::word_t        wd1,
    input  logic                   we0,
    input  logic                   we1,
    input  logic                   write_hi,
    input  logic                   write_lo,
    input  core_pkg::word_t        hi_data,
    input  core_pkg::word_t        lo_data,
    input  core_pkg::regid_t [3:0] rf_raddr,
    output core_pkg::word_t [3:0]  rf_rdata,
    output core_pkg::word_t        hi,
    output core_pkg::word_t        lo
);

    core_pkg::word_t regs [1:31];  // r0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
            hi <= '0;
            lo <= '0;
        end else begin
            if (we0 && wa0 != core_pkg::R0)
                regs[wa0] <= wd0;
            if (we1 && wa1 != core_pkg::R0)
                regs[wa1] <= wd1;  // later lane wins.
            if (write_hi)
                hi <= hi_data;
            if (write_lo)
                lo <= lo_data;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (rf_raddr[i] == core_pkg::R0)
                rf_rdata[i] = '0;
            else
                rf_rdata[i] = regs[rf_raddr[i]];
        end
    end

endmodule

// ==== cp0_regs.sv ====
module cp0_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [5:0]            ext_int,
    input  core_pkg::cp0_update_t cp0_upd,
    output core_pkg::cp0_view_t   cp0
);

    logic            exl;
    logic [7:0]      ip;
    core_pkg::addr_t epc;
    core_pkg::addr_t badvaddr;

    // status and sampled interrupt lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            exl <= 1'b0;
            ip  <= '0;
        end else begin
            ip <= {ext_int, 2'b00};  // software bits stay clear.
            if (cp0_upd.exception_en)
                exl <= 1'b1;
            else if (cp0_upd.eret)
                exl <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cp0_upd.exception_en) begin
            epc <= cp0_upd.epc;
            if (cp0_upd.exe_code == core_pkg::EX_ADEL || cp0_upd.exe_code == core_pkg::EX_ADES)
                badvaddr <= cp0_upd.badvaddr;
        end
    end

    assign cp0.exl      = exl;
    assign cp0.im       = 8'hff;  // every line unmasked.
    assign cp0.ip       = ip;
    assign cp0.epc      = epc;
    assign cp0.badvaddr = badvaddr;

endmodule

// ==== debug_queue.sv ====
module debug_queue #(
    parameter int TRACE_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::trace_t trace0,
    input  core_pkg::trace_t trace1,
    input  logic [1:0]       trace_push,
    output logic             trace_valid,
    output core_pkg::trace_t trace,
    output logic             overflow
);

    localparam int PTR_W = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1;
    localparam int CNT_W = $clog2(TRACE_DEPTH + 1) + 1;  // spare bit for overflow.

    core_pkg::trace_t mem [TRACE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [1:0]       n_push;
    logic             pop;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(TRACE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop         = count != '0;
    assign n_push      = {1'b0, trace_push[0]} + {1'b0, trace_push[1]};
    assign count_next  = count + CNT_W'(n_push) - CNT_W'(pop);
    assign overflow    = count_next > CNT_W'(TRACE_DEPTH);
    assign trace_valid = pop;
    assign trace       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pop)
                rd_ptr <= wrap_inc(rd_ptr);
            if (n_push == 2'd2)
                wr_ptr <= wrap_inc(wrap_inc(wr_ptr));
            else if (n_push == 2'd1)
                wr_ptr <= wrap_inc(wr_ptr);
            count <= count_next;
        end
    end

    // lane 0 lands first, lane 1 right behind it.
    always_ff @(posedge clk) begin
        if (trace_push[0])
            mem[wr_ptr] <= trace0;
        if (trace_push[1])
            mem[trace_push[0] ? wrap_inc(wr_ptr) : wr_ptr] <= trace1;
    end

endmodule

// ==== commit_top.sv ====
module commit_top #(
    parameter int TRACE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  core_pkg::issue_bundle_t issue,
    input  logic [5:0]              ext_int,
    output logic                    trace_valid,
    output core_pkg::trace_t        trace,
    output core_pkg::exc_report_t   exc,
    output logic                    trace_overflow
);

    core_pkg::exec_result_t exec_result;
    core_pkg::regid_t [3:0] rf_raddr;
    core_pkg::word_t [3:0]  rf_rdata;
    core_pkg::word_t        hi;
    core_pkg::word_t        lo;
    core_pkg::cp0_view_t    cp0;
    core_pkg::regid_t       wa0;
    core_pkg::regid_t       wa1;
    core_pkg::word_t        wd0;
    core_pkg::word_t        wd1;
    logic                   we0;
    logic                   we1;
    logic                   write_hi;
    logic                   write_lo;
    core_pkg::word_t        hi_data;
    core_pkg::word_t        lo_data;
    core_pkg::cp0_update_t  cp0_upd;
    core_pkg::trace_t       trace0;
    core_pkg::trace_t       trace1;
    logic [1:0]             trace_push;

    // ========================================================================
    // pipeline
    // ========================================================================
    issue_exec issue_exec_inst (.*);
    commit     commit_inst     (.*);
    arch_state arch_state_inst (.*);
    cp0_regs   cp0_regs_inst   (.*);

    debug_queue #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) debug_queue_inst (
        .overflow (trace_overflow),
        .*
    );

    // one-cycle exception report.
    always_ff @(posedge clk) begin
        exc.valid    <= cp0_upd.exception_en;
        exc.exe_code <= cp0_upd.exe_code;
        exc.bd       <= cp0_upd.bd;
        exc.epc      <= cp0_upd.epc;
        exc.badvaddr <= cp0_upd.badvaddr;
        if (rst)
            exc.valid <= 1'b0;
    end

endmodule

// ==== commit_props.sv ====
module commit_props (
    input logic             clk,
    input logic             rst,
    input logic             exc_valid,
    input core_pkg::ecode_t exc_code,
    input logic             trace_valid,
    input logic             trace_overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // ========================================================================
    // exception report
    // ========================================================================
    exc_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        exc_valid |=> !exc_valid
    ) else begin
        fail_count++;
        $error("exception report held for two cycles");
    end

    exc_has_code: assert property (
        @(posedge clk) disable iff (rst)
        exc_valid |-> exc_code != core_pkg::EX_NONE
    ) else begin
        fail_count++;
        $error("exception report without a cause code");
    end

    // ========================================================================
    // trace queue
    // ========================================================================
    no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        !trace_overflow
    ) else begin
        fail_count++;
        $error("trace queue overflow");
    end

    quiet_after_reset: assert property (
        @(posedge clk)
        rst |=> !trace_valid
    ) else begin
        fail_count++;
        $error("trace valid right after reset");
    end

endmodule

bind commit_top commit_props commit_props_inst (
    .clk            (clk),
    .rst            (rst),
    .exc_valid      (exc.valid),
    .exc_code       (exc.exe_code),
    .trace_valid    (trace_valid),
    .trace_overflow (trace_overflow)
);

// ==== tb_commit.sv ====
module tb_commit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RANDOM     = 300;
    localparam int ISSUE_CYCLES = 2 * (N_RANDOM + 40);
    localparam int TIMEOUT      = ISSUE_CYCLES * 3 + 200;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    issue_valid = 1'b0;
    core_pkg::issue_bundle_t issue = '0;
    logic [5:0]              ext_int = '0;
    logic                    trace_valid;
    core_pkg::trace_t        trace;
    core_pkg::exc_report_t   exc;
    logic                    trace_overflow;

    // shadow architectural state.
    core_pkg::word_t         sh_regs [32];
    core_pkg::word_t         sh_hi;
    core_pkg::word_t         sh_lo;
    logic                    sh_exl;
    core_pkg::addr_t         sh_epc;
    core_pkg::addr_t         pc_next;
    core_pkg::trace_t        exp_trace [$];
    core_pkg::exc_report_t   exp_exc [$];
    int                      cycles = 0;

    commit_top #(.TRACE_DEPTH(8)) commit_top_inst (.*);

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        $display("ERR t=%0t %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "check failed");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic core_pkg::micro_op_t make_uop(input core_pkg::fu_t fu,
            input core_pkg::op_t op, input core_pkg::regid_t rs, input core_pkg::regid_t rt,
            input core_pkg::regid_t rd, input core_pkg::word_t imm);
        core_pkg::micro_op_t u;
        u            = '0;
        u.valid      = 1'b1;
        u.fu         = fu;
        u.op         = op;
        u.rs         = rs;
        u.rt         = rt;
        u.target_reg = rd;
        u.imm        = imm;
        return u;
    endfunction

    task automatic eval_lane(input core_pkg::micro_op_t u, output core_pkg::word_t res,
            output core_pkg::regid_t tgt, output core_pkg::ecode_t cause,
            output core_pkg::addr_t bva, output logic [63:0] prod);
        longint a;
        longint b;
        longint s;
        logic   ov;
        logic   mis;
        a     = longint'($signed(sh_regs[u.rs]));
        b     = longint'($signed(sh_regs[u.rt]));
        s     = (u.op == core_pkg::OP_SUB) ? a - b : a + b;
        ov    = 1'b0;
        mis   = 1'b0;
        tgt   = u.target_reg;
        bva   = '0;
        prod  = a * b;
        res   = '0;
        case (u.fu)
            core_pkg::ALU: begin
                res = s[31:0];
                ov  = s > 64'sd2147483647 || s < -64'sd2147483648;
            end
            core_pkg::BRU: begin
                res = u.pc + 32'd8;
                tgt = core_pkg::RA;
            end
            core_pkg::AGU: begin
                res = sh_regs[u.rs] + u.imm;
                bva = res;
                mis = res[1:0] != 2'b00;
            end
            core_pkg::HILO: res = (u.op == core_pkg::OP_MFHI) ? sh_hi : sh_lo;
            core_pkg::CP0:  res = sh_epc;
            core_pkg::MLT:  res = prod[31:0];
            default:        tgt = core_pkg::R0;
        endcase
        if (u.ri)
            cause = core_pkg::EX_RI;
        else if (ov)
            cause = core_pkg::EX_OV;
        else if (u.syscall)
            cause = core_pkg::EX_SYS;
        else if (u.brk)
            cause = core_pkg::EX_BP;
        else if (mis && u.op == core_pkg::OP_LW)
            cause = core_pkg::EX_ADEL;
        else if (mis && u.op == core_pkg::OP_SW)
            cause = core_pkg::EX_ADES;
        else
            cause = core_pkg::EX_NONE;
    endtask

    task automatic predict(input core_pkg::issue_bundle_t b);
        core_pkg::word_t       res [2];
        core_pkg::regid_t      tgt [2];
        core_pkg::ecode_t      cause [2];
        core_pkg::addr_t       bva [2];
        logic [63:0]           prod [2];
        logic                  keep [2];
        logic                  lane0_exc;
        core_pkg::exc_report_t e;
        core_pkg::trace_t      t;
        for (int i = 0; i < 2; i++) begin
            eval_lane(b.lane[i], res[i], tgt[i], cause[i], bva[i], prod[i]);
            keep[i] = b.lane[i].valid;
        end
        e          = '0;
        e.exe_code = core_pkg::EX_NONE;
        lane0_exc  = 1'b0;
        if (keep[0] && !sh_exl && ext_int != '0) begin
            e.valid    = 1'b1;
            e.exe_code = core_pkg::EX_INT;
            e.epc      = b.lane[0].pc + 32'd4;
            lane0_exc  = 1'b1;
        end else if (keep[0] && cause[0] != core_pkg::EX_NONE) begin
            e = '{valid: 1'b1, exe_code: cause[0], bd: 1'b0, epc: b.lane[0].pc, badvaddr: bva[0]};
            lane0_exc = 1'b1;
        end else if (keep[1] && cause[1] != core_pkg::EX_NONE) begin
            e = '{valid: 1'b1, exe_code: cause[1], bd: 1'b0, epc: b.lane[1].pc, badvaddr: bva[1]};
            if (keep[0] && b.lane[0].fu == core_pkg::BRU) begin
                e.bd  = 1'b1;
                e.epc = b.lane[1].pc - 32'd4;
            end
        end
        if (e.valid) begin
            keep[1] = 1'b0;
            if (lane0_exc)
                keep[0] = 1'b0;  // lane 0 cause squashes both.
            exp_exc.push_back(e);
            sh_exl = 1'b1;
            sh_epc = e.epc;
        end
        for (int i = 0; i < 2; i++) begin
            if (keep[i]) begin
                t.pc    = b.lane[i].pc;
                t.wnum  = tgt[i];
                t.wen   = tgt[i] != core_pkg::R0;
                t.wdata = t.wen ? res[i] : '0;
                exp_trace.push_back(t);
                if (t.wen)
                    sh_regs[tgt[i]] = res[i];
                if (b.lane[i].fu == core_pkg::MLT) begin
                    sh_hi = prod[i][63:32];
                    sh_lo = prod[i][31:0];
                end
                if (b.lane[i].op == core_pkg::OP_ERET && b.lane[i].fu == core_pkg::CP0
                        && !e.valid)
                    sh_exl = 1'b0;
            end
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic send(input core_pkg::micro_op_t u0, input core_pkg::micro_op_t u1);
        core_pkg::issue_bundle_t b;
        b.lane[0]    = u0;
        b.lane[1]    = u1;
        b.lane[0].pc = pc_next;
        b.lane[1].pc = pc_next + 32'd4;
        pc_next      = pc_next + 32'd8;
        @(negedge clk);
        issue       = b;
        issue_valid = 1'b1;
        predict(b);
        @(negedge clk);
        issue_valid = 1'b0;
        issue       = '0;
    endtask

    task automatic raise_interrupt();
        @(negedge clk);
        ext_int = 6'b000001;
        send(make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd2, 5'd11, '0),
             make_uop(core_pkg::ALU, core_pkg::OP_SUB, 5'd1, 5'd2, 5'd12, '0));
        ext_int = '0;
    endtask

    function automatic core_pkg::micro_op_t random_uop();
        core_pkg::op_t op;
        case ($urandom_range(0, 4))
            0: return make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'($urandom), 5'($urandom),
                               5'($urandom), '0);
            1: return make_uop(core_pkg::ALU, core_pkg::OP_SUB, 5'($urandom), 5'($urandom),
                               5'($urandom), '0);
            2: return make_uop(core_pkg::BRU, core_pkg::OP_LINK, '0, '0, core_pkg::RA, '0);
            3: return make_uop(core_pkg::MLT, core_pkg::OP_MULT, 5'($urandom), 5'($urandom),
                               core_pkg::R0, '0);
            default: begin
                op = $urandom_range(0, 1) ? core_pkg::OP_MFHI : core_pkg::OP_MFLO;
                return make_uop(core_pkg::HILO, op, '0, '0, 5'($urandom), '0);
            end
        endcase
    endfunction

    core_pkg::micro_op_t nop_uop;
    core_pkg::micro_op_t eret_uop;
    core_pkg::micro_op_t ri_uop;

    initial begin
        void'($urandom(48358));
        for (int i = 0; i < 32; i++)
            sh_regs[i] = '0;
        sh_hi    = '0;
        sh_lo    = '0;
        sh_exl   = 1'b0;
        sh_epc   = '0;
        pc_next  = 32'h0000_1000;
        nop_uop  = '0;
        eret_uop = make_uop(core_pkg::CP0, core_pkg::OP_ERET, '0, '0, core_pkg::R0, '0);
        ri_uop   = make_uop(core_pkg::ALU, core_pkg::OP_ADD, '0, '0, 5'd10, '0);
        ri_uop.ri = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send(make_uop(core_pkg::AGU, core_pkg::OP_LW, '0, '0, 5'd1, 32'h100),
             make_uop(core_pkg::AGU, core_pkg::OP_LW, '0, '0, 5'd2, 32'h24));
        send(make_uop(core_pkg::AGU, core_pkg::OP_LW, '0, '0, 5'd3, 32'h7fff_fffc),
             make_uop(core_pkg::AGU, core_pkg::OP_LW, '0, '0, 5'd4, 32'hffff_fff8));
        send(make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd2, 5'd5, '0),
             make_uop(core_pkg::ALU, core_pkg::OP_SUB, 5'd1, 5'd2, 5'd6, '0));
        send(make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd2, core_pkg::R0, '0),
             make_uop(core_pkg::ALU, core_pkg::OP_SUB, 5'd2, 5'd1, 5'd7, '0));
        send(make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd3, 5'd3, 5'd8, '0),
             make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd1, 5'd9, '0));
        send(make_uop(core_pkg::BRU, core_pkg::OP_LINK, '0, '0, core_pkg::RA, '0), ri_uop);
        send(eret_uop, nop_uop);

        // interrupt, read back epc, return, interrupt again.
        raise_interrupt();
        send(make_uop(core_pkg::CP0, core_pkg::OP_MFC0_EPC, '0, '0, 5'd13, '0), nop_uop);
        send(eret_uop, nop_uop);
        raise_interrupt();
        send(eret_uop, nop_uop);

        send(make_uop(core_pkg::MLT, core_pkg::OP_MULT, 5'd4, 5'd2, core_pkg::R0, '0), nop_uop);
        send(make_uop(core_pkg::HILO, core_pkg::OP_MFHI, '0, '0, 5'd14, '0),
             make_uop(core_pkg::HILO, core_pkg::OP_MFLO, '0, '0, 5'd15, '0));
        send(make_uop(core_pkg::AGU, core_pkg::OP_LW, 5'd1, '0, core_pkg::R0, 32'd2),
             make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd2, 5'd16, '0));
        send(make_uop(core_pkg::ALU, core_pkg::OP_ADD, 5'd1, 5'd2, 5'd17, '0),
             make_uop(core_pkg::AGU, core_pkg::OP_SW, 5'd2, '0, core_pkg::R0, 32'd1));

        for (int n = 0; n < N_RANDOM; n++)
            send(random_uop(), random_uop());

        repeat (30) @(negedge clk);
        if (exp_trace.size() == 0 && exp_exc.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("expected records never appeared: %0d trace, %0d exception",
                     exp_trace.size(), exp_exc.size());
            $display("Simulation finished: FAIL");
            $fatal(1, "missing output");
        end
    end

    // ========================================================================
    // output checks
    // ========================================================================
    always @(negedge clk) begin : check_outputs
        core_pkg::trace_t      want_t;
        core_pkg::exc_report_t want_e;
        if (commit_top_inst.commit_props_inst.fail_count != 0)
            report_error("a concurrent assertion bound to commit_top failed");
        if (!rst && trace_valid) begin
            assert (exp_trace.size() > 0)
                else report_error("trace record with none expected");
            want_t = exp_trace.pop_front();
            assert (trace === want_t)
                else report_error($sformatf("trace got %h want %h", trace, want_t));
        end
        if (!rst && exc.valid) begin
            assert (exp_exc.size() > 0)
                else report_error("exception report with none expected");
            want_e = exp_exc.pop_front();
            assert (exc === want_e)
                else report_error($sformatf("exception got %h want %h", exc, want_e));
        end
    end

endmodule

// ==== src.f ====
core_pkg.sv
issue_exec.sv
commit.sv
arch_state.sv
cp0_regs.sv
debug_queue.sv
commit_top.sv
commit_props.sv
tb_commit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the commit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_commit -f src.f -o sim_commit
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_commit > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "no pass line in log"
    exit 1
fi
exit 0
